//--- dla_simulate.f
hw/dla_pkg.sv
hw/dla_lfsr.sv
hw/dla_vram_init.sv
hw/dla_particle_check.sv
hw/dla_particle_walk.sv
hw/dla_simulate.sv
testbench/vram_model.sv
testbench/dla_simulate_tb.sv

//--- hw/dla_lfsr.sv
// DLA random source
// Galois LFSR, loads SEED on reset and advances one step per shift strobe
module dla_lfsr #(
    parameter logic [dla_pkg::DLA_LFSR_W-1:0] SEED = 16'h0001,
    parameter logic [dla_pkg::DLA_LFSR_W-1:0] TAP  = 16'hD008
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            shift,
    output logic [dla_pkg::DLA_LFSR_W-1:0]  value
);

    logic [dla_pkg::DLA_LFSR_W-1:0] value_next;

    // Shift right, fold the taps in when a one falls out
    always_comb begin
        value_next = value >> 1;
        if (value[0]) begin
            value_next = value_next ^ TAP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= SEED;                      // Must be non-zero
        end else if (shift) begin
            value <= value_next;
        end
    end

endmodule

//--- hw/dla_particle_check.sv
// DLA particle check
// Reads a pixel and its four neighbours from VRAM and reports whether
// the point is on the edge, already occupied, or touching the cluster
module dla_particle_check (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  check_start,
    input  dla_pkg::dla_point_t   check_point,
    output logic                  check_done,
    output logic                  hit_boundary,
    output logic                  hit_occupied,
    output logic                  hit_neighbor,
    output dla_pkg::dla_avn_req_t avn_req,
    input  dla_pkg::dla_avn_rsp_t avn_rsp
);

    import dla_pkg::*;

    logic       busy;
    dla_point_t centre;         // Latched point under test
    dla_point_t rd_point;
    logic [2:0] rd_cnt;         // Reads accepted
    logic [2:0] rsp_cnt;        // Read data returned
    logic       on_edge;

    assign on_edge = (check_point.x == '0) || (check_point.x == DLA_XW'(DLA_HSIZE - 1)) ||
                     (check_point.y == '0) || (check_point.y == DLA_YW'(DLA_VSIZE - 1));

    // ----------------------------------------
    // Read address sequence
    // ----------------------------------------
    // Centre, north, south, west, east
    always_comb begin
        rd_point = centre;
        case (rd_cnt)
            3'd1: rd_point.y = centre.y - 1'b1;
            3'd2: rd_point.y = centre.y + 1'b1;
            3'd3: rd_point.x = centre.x - 1'b1;
            3'd4: rd_point.x = centre.x + 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        avn_req.address   = rd_point;
        avn_req.read      = busy && (rd_cnt != 3'd5);
        avn_req.write     = 1'b0;
        avn_req.writedata = DLA_PIXEL_OFF;
    end

    always_ff @(posedge clk) begin
        if (check_start && !busy) centre <= check_point;
    end

    // ----------------------------------------
    // Control and response collection
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            rd_cnt       <= '0;
            rsp_cnt      <= '0;
            check_done   <= 1'b0;
            hit_boundary <= 1'b0;
            hit_occupied <= 1'b0;
            hit_neighbor <= 1'b0;
        end else begin
            check_done <= 1'b0;
            if (!busy) begin
                if (check_start) begin
                    rd_cnt       <= '0;
                    rsp_cnt      <= '0;
                    hit_boundary <= on_edge;
                    hit_occupied <= 1'b0;
                    hit_neighbor <= 1'b0;
                    busy         <= !on_edge;
                    check_done   <= on_edge;    // Edge needs no reads
                end
            end else begin
                // Reads may run ahead of the returned data
                if (avn_req.read && !avn_rsp.waitrequest) rd_cnt <= rd_cnt + 1'b1;
                if (avn_rsp.readdatavalid) begin
                    rsp_cnt <= rsp_cnt + 1'b1;
                    if (avn_rsp.readdata != DLA_PIXEL_OFF) begin
                        if (rsp_cnt == 3'd0) hit_occupied <= 1'b1;
                        else                 hit_neighbor <= 1'b1;
                    end
                    if (rsp_cnt == 3'd4) begin  // Last of five
                        busy       <= 1'b0;
                        check_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- hw/dla_particle_walk.sv
// DLA particle walk
// Moves one particle in random unit steps, checking its surroundings
// before each step, and writes the pixel where it sticks
module dla_particle_walk (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  walk_start,
    input  dla_pkg::dla_point_t   walk_point,
    input  logic [1:0]            dir_bits,
    output logic                  walk_done,
    output logic                  walk_valid,
    output logic                  step_shift,
    output logic                  check_start,
    output dla_pkg::dla_point_t   check_point,
    input  logic                  check_done,
    input  logic                  hit_boundary,
    input  logic                  hit_occupied,
    input  logic                  hit_neighbor,
    output dla_pkg::dla_avn_req_t avn_req,
    input  dla_pkg::dla_avn_rsp_t avn_rsp
);

    import dla_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHECK,
        S_WAIT,
        S_STEP,
        S_WRITE
    } state_t;

    state_t                         state;
    dla_point_t                     pos;
    logic [$clog2(DLA_MAX_STEPS):0] steps;

    assign check_start = (state == S_CHECK);
    assign check_point = pos;
    assign step_shift  = (state == S_STEP);     // Fresh direction for next step

    always_comb begin
        avn_req.address   = pos;
        avn_req.read      = 1'b0;
        avn_req.write     = (state == S_WRITE);
        avn_req.writedata = DLA_PIXEL_ON;
    end

    // Position, always interior when a step is taken
    always_ff @(posedge clk) begin
        if (state == S_IDLE && walk_start) begin
            pos <= walk_point;
        end else if (state == S_STEP) begin
            case (dir_bits)
                2'd0: pos.y <= pos.y - 1'b1;    // North
                2'd1: pos.y <= pos.y + 1'b1;    // South
                2'd2: pos.x <= pos.x - 1'b1;    // West
                2'd3: pos.x <= pos.x + 1'b1;    // East
            endcase
        end
    end

    // ----------------------------------------
    // Walk sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            steps      <= '0;
            walk_done  <= 1'b0;
            walk_valid <= 1'b0;
        end else begin
            walk_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (walk_start) begin
                        steps <= '0;
                        state <= S_CHECK;
                    end
                end
                S_CHECK: state <= S_WAIT;
                S_WAIT: begin
                    if (check_done) begin
                        if (hit_boundary || hit_occupied || steps == DLA_MAX_STEPS) begin
                            walk_done  <= 1'b1;     // Discarded
                            walk_valid <= 1'b0;
                            state      <= S_IDLE;
                        end else if (hit_neighbor) begin
                            state <= S_WRITE;
                        end else begin
                            state <= S_STEP;
                        end
                    end
                end
                S_STEP: begin
                    steps <= steps + 1'b1;
                    state <= S_CHECK;
                end
                S_WRITE: begin
                    if (!avn_rsp.waitrequest) begin
                        walk_done  <= 1'b1;
                        walk_valid <= 1'b1;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- hw/dla_pkg.sv
// DLA package
// Grid geometry, pixel values, Avalon-MM widths and the structs
// shared by the engine blocks and the top level
package dla_pkg;

    // ----------------------------------------
    // Grid geometry
    // ----------------------------------------
    localparam int DLA_XW    = 6;
    localparam int DLA_YW    = 6;
    localparam int DLA_HSIZE = 64;
    localparam int DLA_VSIZE = 64;

    // ----------------------------------------
    // VRAM word layout
    // ----------------------------------------
    localparam int DLA_AW = DLA_YW + DLA_XW;           // Word address is {y, x}
    localparam int DLA_DW = 16;
    localparam logic [DLA_DW-1:0] DLA_PIXEL_ON  = '1;
    localparam logic [DLA_DW-1:0] DLA_PIXEL_OFF = '0;

    localparam int DLA_MAX_STEPS = 4096;               // Walk length before discard
    localparam int DLA_LFSR_W    = 16;

    // Grid point, bit layout equals the VRAM word address
    typedef struct packed {
        logic [DLA_YW-1:0] y;
        logic [DLA_XW-1:0] x;
    } dla_point_t;

    // Avalon-MM master side
    typedef struct packed {
        logic [DLA_AW-1:0] address;
        logic              read;
        logic              write;
        logic [DLA_DW-1:0] writedata;
    } dla_avn_req_t;

    // Avalon-MM slave side
    typedef struct packed {
        logic              waitrequest;
        logic              readdatavalid;
        logic [DLA_DW-1:0] readdata;
    } dla_avn_rsp_t;

endpackage

//--- hw/dla_simulate.sv
// DLA engine top level
// Sequences image init and particle walks, counts stuck particles and
// arbitrates the three VRAM masters onto one Avalon-MM port
module dla_simulate #(
    parameter int PARTICLE_COUNT = 2000
) (
    input  logic                  clk,
    input  logic                  rst,
    output dla_pkg::dla_avn_req_t vram_req,
    input  dla_pkg::dla_avn_rsp_t vram_rsp,
    output logic                  sim_done
);

    import dla_pkg::*;

    typedef enum logic [4:0] {
        S_IDLE = 5'b00001,
        S_INIT = 5'b00010,
        S_NEW  = 5'b00100,
        S_WALK = 5'b01000,
        S_DONE = 5'b10000
    } state_t;

    typedef logic [$clog2(PARTICLE_COUNT + 1)-1:0] count_t;

    state_t                state;
    state_t                state_next;
    count_t                par_left;           // Particles still to stick
    logic                  init_start, init_done;
    logic                  walk_start, walk_done, walk_valid, step_shift;
    logic                  check_start, check_done;
    logic                  hit_boundary, hit_occupied, hit_neighbor;
    dla_point_t            walk_point, check_point;
    dla_avn_req_t          init_req, walk_req, check_req;
    logic [DLA_LFSR_W-1:0] x_rand, y_rand, dir_rand;

    assign walk_point.x = x_rand[DLA_XW-1:0];
    assign walk_point.y = y_rand[DLA_YW-1:0];
    assign sim_done     = (state == S_DONE);

    // ----------------------------------------
    // Sequencing FSM
    // ----------------------------------------
    always_comb begin
        init_start = 1'b0;
        walk_start = 1'b0;
        state_next = state;
        case (state)
            S_IDLE: begin
                init_start = 1'b1;
                state_next = S_INIT;
            end
            S_INIT: if (init_done) state_next = S_NEW;
            S_NEW: begin
                walk_start = 1'b1;
                state_next = S_WALK;
            end
            S_WALK: begin
                if (walk_done) begin
                    if (walk_valid && par_left == count_t'(1)) state_next = S_DONE;
                    else                                       state_next = S_NEW;
                end
            end
            default: state_next = S_DONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            par_left <= count_t'(PARTICLE_COUNT);
        end else begin
            state <= state_next;
            if (walk_done && walk_valid) par_left <= par_left - 1'b1;
        end
    end

    // Init, then walk write, then check read; only one is ever active
    always_comb begin
        if (init_req.write)      vram_req = init_req;
        else if (walk_req.write) vram_req = walk_req;
        else                     vram_req = check_req;
    end

    // ----------------------------------------
    // Sub-blocks
    // ----------------------------------------
    dla_vram_init vram_init_i (
        .clk, .rst, .init_start, .init_done,
        .avn_req (init_req),
        .avn_rsp (vram_rsp)
    );

    dla_particle_check particle_check_i (
        .clk, .rst, .check_start, .check_point, .check_done,
        .hit_boundary, .hit_occupied, .hit_neighbor,
        .avn_req (check_req),
        .avn_rsp (vram_rsp)
    );

    dla_particle_walk particle_walk_i (
        .clk, .rst, .walk_start, .walk_point,
        .dir_bits (dir_rand[1:0]),
        .walk_done, .walk_valid, .step_shift,
        .check_start, .check_point, .check_done,
        .hit_boundary, .hit_occupied, .hit_neighbor,
        .avn_req  (walk_req),
        .avn_rsp  (vram_rsp)
    );

    dla_lfsr #(.SEED(16'hABCD)) lfsr_x_i (
        .clk, .rst, .shift (walk_start), .value (x_rand)
    );

    dla_lfsr #(.SEED(16'h1234)) lfsr_y_i (
        .clk, .rst, .shift (walk_start), .value (y_rand)
    );

    dla_lfsr #(.SEED(16'h5A5A), .TAP(16'hB400)) lfsr_dir_i (
        .clk, .rst, .shift (step_shift), .value (dir_rand)
    );

endmodule

//--- hw/dla_vram_init.sv
// DLA VRAM initialisation
// Sweeps the whole image writing free pixels, then places the seed
// pixel at the centre and pulses init_done
module dla_vram_init (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  init_start,
    output logic                  init_done,
    output dla_pkg::dla_avn_req_t avn_req,
    input  dla_pkg::dla_avn_rsp_t avn_rsp
);

    import dla_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CLEAR,
        S_SEED
    } state_t;

    state_t            state;
    logic [DLA_AW-1:0] addr;
    logic [DLA_AW-1:0] seed_addr;
    logic              accepted;

    assign seed_addr = {DLA_YW'(DLA_VSIZE / 2), DLA_XW'(DLA_HSIZE / 2)};
    assign accepted  = avn_req.write && !avn_rsp.waitrequest;

    always_comb begin
        avn_req.read      = 1'b0;
        avn_req.write     = (state != S_IDLE);
        avn_req.address   = (state == S_SEED) ? seed_addr : addr;
        avn_req.writedata = (state == S_SEED) ? DLA_PIXEL_ON : DLA_PIXEL_OFF;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            addr      <= '0;
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (init_start) begin
                        addr  <= '0;
                        state <= S_CLEAR;
                    end
                end
                S_CLEAR: begin
                    if (accepted) begin
                        addr <= addr + 1'b1;    // Holds while stalled
                        if (addr == DLA_AW'(DLA_HSIZE * DLA_VSIZE - 1)) state <= S_SEED;
                    end
                end
                S_SEED: begin
                    if (accepted) begin
                        init_done <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- testbench/dla_simulate_tb.sv
// DLA engine testbench
// Grows a small cluster against the VRAM model and checks the init
// sweep, Avalon stall behaviour, the stick rule and the done flag
module dla_simulate_tb;

    import dla_pkg::*;

    localparam int PARTICLES       = 6;
    localparam int PIXELS          = DLA_HSIZE * DLA_VSIZE;
    localparam int WATCHDOG_CYCLES = 2 * (PIXELS + 1 + PARTICLES * DLA_MAX_STEPS * 12);
    localparam int QUIET_CYCLES    = 200;

    logic         clk;
    logic         rst;
    dla_avn_req_t vram_req;
    dla_avn_rsp_t vram_rsp;
    logic         sim_done;

    logic shadow [PIXELS];                  // Occupancy as written so far
    int   stick_cnt;
    int   err_reset, err_init, err_stall, err_stick, err_done;

    dla_simulate #(.PARTICLE_COUNT(PARTICLES)) dla_simulate_i (
        .clk, .rst, .vram_req, .vram_rsp, .sim_done
    );

    vram_model #(.SEED(32'h917a_23cf)) vram_model_i (
        .clk, .rst, .req (vram_req), .rsp (vram_rsp)
    );

    always #2 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic bus_quiet();
        return !(vram_req.read || vram_req.write);
    endfunction

    function automatic logic write_accepted();
        return vram_req.write && !vram_rsp.waitrequest;
    endfunction

    function automatic logic pixel_at(input logic [DLA_YW-1:0] y, input logic [DLA_XW-1:0] x);
        return shadow[{y, x}];
    endfunction

    function automatic int total_errors();
        return err_reset + err_init + err_stall + err_stick + err_done;
    endfunction

    task automatic report_counts();
        $display("errors: reset %0d init %0d stall %0d stick %0d done %0d",
                 err_reset, err_init, err_stall, err_stick, err_done);
    endtask

    task automatic check_stick(input logic [DLA_AW-1:0] addr, input logic [DLA_DW-1:0] data);
        dla_point_t p;
        logic       on_edge;
        logic       touches;
        p       = addr;
        on_edge = (p.x == 0) || (p.x == DLA_HSIZE - 1) || (p.y == 0) || (p.y == DLA_VSIZE - 1);
        touches = 1'b0;
        if (!on_edge) begin
            touches = pixel_at(p.y - 1'b1, p.x) || pixel_at(p.y + 1'b1, p.x) ||
                      pixel_at(p.y, p.x - 1'b1) || pixel_at(p.y, p.x + 1'b1);
        end
        assert (data == DLA_PIXEL_ON) else begin
            $display("mismatch vram_req.writedata: got %h, expected %h", data, DLA_PIXEL_ON);
            err_stick++;
        end
        assert (!on_edge) else begin
            $display("particle written on the image edge at address %h", addr);
            err_stick++;
        end
        assert (!shadow[addr]) else begin
            $display("particle written over an occupied pixel at address %h", addr);
            err_stick++;
        end
        assert (on_edge || touches) else begin
            $display("particle written with no occupied neighbour at address %h", addr);
            err_stick++;
        end
        shadow[addr] = 1'b1;
        stick_cnt++;
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_idle();
        repeat (7) begin
            @(negedge clk);
            assert (bus_quiet() && !sim_done) else begin
                $display("request or sim_done active while reset is held");
                err_reset++;
            end
        end
        @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        assert (bus_quiet() && !sim_done) else begin
            $display("request or sim_done active on the first cycle after reset");
            err_reset++;
        end
    endtask

    task automatic test_stall_hold();
        dla_avn_req_t prev_req;
        logic         prev_stall;
        prev_stall = 1'b0;
        forever begin
            @(negedge clk);
            if (prev_stall) begin
                assert (vram_req == prev_req) else begin
                    $display("mismatch vram_req under waitrequest: got %h, held %h",
                             vram_req, prev_req);
                    err_stall++;
                end
            end
            prev_req   = vram_req;
            prev_stall = !bus_quiet() && vram_rsp.waitrequest;
        end
    endtask

    task automatic test_init_clear();
        int                n;
        logic [DLA_AW-1:0] exp_addr;
        logic [DLA_DW-1:0] exp_data;
        n = 0;
        while (n <= PIXELS) begin
            @(negedge clk);
            if (write_accepted()) begin
                if (n < PIXELS) begin
                    exp_addr = DLA_AW'(n);
                    exp_data = DLA_PIXEL_OFF;
                end else begin
                    exp_addr = {6'd32, 6'd32};      // Seed
                    exp_data = DLA_PIXEL_ON;
                end
                assert (vram_req.address == exp_addr && vram_req.writedata == exp_data) else begin
                    $display("mismatch vram_req.address/writedata: got %h/%h, expected %h/%h",
                             vram_req.address, vram_req.writedata, exp_addr, exp_data);
                    err_init++;
                end
                shadow[vram_req.address] = (vram_req.writedata != DLA_PIXEL_OFF);
                n++;
            end
        end
    endtask

    task automatic test_stick_rule();
        @(negedge clk);
        while (!sim_done) begin
            if (write_accepted()) check_stick(vram_req.address, vram_req.writedata);
            @(negedge clk);
        end
    endtask

    task automatic test_count_done();
        assert (stick_cnt == PARTICLES) else begin
            $display("mismatch stuck particles at sim_done: got %h, expected %h",
                     stick_cnt, PARTICLES);
            err_done++;
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (bus_quiet() && sim_done) else begin
                $display("request seen or sim_done dropped after the run finished");
                err_done++;
            end
        end
    endtask

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        stick_cnt = 0;
        err_reset = 0;
        err_init  = 0;
        err_stall = 0;
        err_stick = 0;
        err_done  = 0;
        test_reset_idle();
        fork
            test_stall_hold();              // Runs for the whole simulation
        join_none
        test_init_clear();
        test_stick_rule();
        test_count_done();
        report_counts();
        if (total_errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Init sweep plus every particle at the step limit, doubled for stalls
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: sim_done not reached within %0d cycles", WATCHDOG_CYCLES);
        report_counts();
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- testbench/vram_model.sv
// VRAM model
// Avalon-MM slave memory with random waitrequest stalls and a fixed
// two-cycle read latency
module vram_model #(
    parameter logic [31:0] SEED = 32'h917a_23cf
) (
    input  logic                  clk,
    input  logic                  rst,
    input  dla_pkg::dla_avn_req_t req,
    output dla_pkg::dla_avn_rsp_t rsp
);

    import dla_pkg::*;

    logic [DLA_DW-1:0] mem [DLA_HSIZE*DLA_VSIZE];
    dla_avn_req_t      req_s;               // Request as seen before the edge
    logic              wait_s;
    logic              rd_valid_q;          // First latency stage
    logic [DLA_DW-1:0] rd_data_q;

    // Bus is settled at the falling edge
    always @(negedge clk) begin
        req_s  = req;
        wait_s = rsp.waitrequest;
    end

    initial begin
        for (int i = 0; i < DLA_HSIZE * DLA_VSIZE; i++) begin
            mem[i] = DLA_DW'(i) ^ 16'hC3A5;     // Junk until the engine clears it
        end
        rsp        = '0;
        req_s      = '0;
        wait_s     = 1'b0;
        rd_valid_q = 1'b0;
        rd_data_q  = '0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            #1;
            // Second latency stage
            rsp.readdatavalid = rd_valid_q && !rst;
            rsp.readdata      = rd_data_q;
            rd_valid_q        = 1'b0;
            if (!rst && !wait_s) begin
                if (req_s.write) mem[req_s.address] = req_s.writedata;
                if (req_s.read) begin
                    rd_valid_q = 1'b1;
                    rd_data_q  = mem[req_s.address];
                end
            end
            rsp.waitrequest = ($urandom_range(3) == 0);   // About one cycle in four
        end
    end

endmodule
